//--- rv_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the five-stage RV32I subset core.
// Opcodes, ALU operations, instruction layouts and the
// structs carried between pipeline stages.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package rv_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opc_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0]       imm;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } instr_i_t;

    // One instruction word, two ways to read it
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src;
        logic    mem_to_reg;
        logic    branch;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instr_u          instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t             ctrl;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
        logic [XLEN-1:0]   imm;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        logic              reg_write;
        logic              mem_read;
        logic              mem_write;
        logic              mem_to_reg;
        logic [XLEN-1:0]   alu;
        logic [XLEN-1:0]   store_data;
        logic [REG_AW-1:0] rd;
    } ex_mem_t;

    // Register write request from the last stage
    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } wb_t;

endpackage

//--- rv_fetch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage: PC, instruction memory with a loader
// write port, and the IF/ID register.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rv_fetch #(
    parameter int IMEM_AW = 6
) (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_run,
    input  logic                     i_load_en,
    input  logic [IMEM_AW-1:0]       i_load_addr,
    input  logic [rv_pkg::XLEN-1:0]  i_load_data,
    input  logic                     i_stall,
    input  logic                     i_flush,
    input  logic [rv_pkg::XLEN-1:0]  i_target,
    output logic [rv_pkg::XLEN-1:0]  o_pc,
    output rv_pkg::if_id_t           o_if_id
);
    import rv_pkg::*;

    logic [XLEN-1:0] imem [2**IMEM_AW];
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] instr;
    if_id_t          if_id_q;

    // Loader writes land on the same edge as the strobe
    always_ff @(posedge clk) begin
        if (i_load_en) begin
            imem[i_load_addr] <= i_load_data;
        end
    end

    // Word-addressed, read straight at the PC
    assign instr = imem[pc_q[IMEM_AW+1:2]];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pc_q <= '0;
        end else if (i_run) begin
            if (i_flush) begin
                pc_q <= i_target;
            end else if (!i_stall) begin
                pc_q <= pc_q + XLEN'(4);
            end
        end
    end

    // Flush wins over stall
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            if_id_q.valid <= 1'b0;
        end else if (i_run) begin
            if (i_flush) begin
                if_id_q.valid <= 1'b0;
            end else if (!i_stall) begin
                if_id_q.valid <= 1'b1;
                if_id_q.pc    <= pc_q;
                if_id_q.instr <= instr;
            end
        end
    end

    assign o_pc    = pc_q;
    assign o_if_id = if_id_q;

endmodule

//--- rv_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage: register file with debug read port,
// control and immediate decode, load-use detection
// and the ID/EX register.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rv_decode (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_run,
    input  rv_pkg::if_id_t            i_if_id,
    input  logic                      i_flush,
    input  rv_pkg::wb_t               i_wb,
    input  logic [rv_pkg::REG_AW-1:0] i_dbg_addr,
    output logic                      o_stall,
    output rv_pkg::id_ex_t            o_id_ex,
    output logic [rv_pkg::XLEN-1:0]   o_dbg_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [2**REG_AW];
    instr_u          ins;
    ctrl_t           ctrl_d;
    logic [XLEN-1:0] imm_d;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            uses_rs2;
    logic [XLEN-1:0] dbg_q;
    id_ex_t          id_ex_q;

    assign ins = i_if_id.instr;

    // x0 is never written, so it keeps its reset value
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int k = 0; k < 2**REG_AW; k++) begin
                regs[k] <= '0;
            end
        end else if (i_run && i_wb.we && i_wb.rd != '0) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // Same-cycle write goes straight to the read ports
    assign rs1_data = (i_wb.we && i_wb.rd == ins.r.rs1 && ins.r.rs1 != '0) ?
                      i_wb.data : regs[ins.r.rs1];
    assign rs2_data = (i_wb.we && i_wb.rd == ins.r.rs2 && ins.r.rs2 != '0) ?
                      i_wb.data : regs[ins.r.rs2];

    always_comb begin
        ctrl_d   = '0;
        imm_d    = {{20{ins.i.imm[11]}}, ins.i.imm};
        uses_rs2 = 1'b0;
        case (ins.r.opcode)
            OPC_OP: begin
                ctrl_d.reg_write = 1'b1;
                uses_rs2         = 1'b1;
                case (ins.r.funct3)
                    3'b111:  ctrl_d.alu_op = ALU_AND;
                    3'b110:  ctrl_d.alu_op = ALU_OR;
                    3'b100:  ctrl_d.alu_op = ALU_XOR;
                    3'b010:  ctrl_d.alu_op = ALU_SLT;
                    default: ctrl_d.alu_op = ins.r.funct7[5] ? ALU_SUB : ALU_ADD;
                endcase
            end
            OPC_OP_IMM: begin
                ctrl_d.reg_write = 1'b1;
                ctrl_d.alu_src   = 1'b1;
            end
            OPC_LOAD: begin
                ctrl_d.reg_write  = 1'b1;
                ctrl_d.mem_read   = 1'b1;
                ctrl_d.mem_to_reg = 1'b1;
                ctrl_d.alu_src    = 1'b1;
            end
            OPC_STORE: begin
                ctrl_d.mem_write = 1'b1;
                ctrl_d.alu_src   = 1'b1;
                uses_rs2         = 1'b1;
                imm_d = {{20{ins.r.funct7[6]}}, ins.r.funct7, ins.r.rd};
            end
            OPC_BRANCH: begin
                ctrl_d.branch = 1'b1;
                ctrl_d.alu_op = ALU_SUB;
                uses_rs2      = 1'b1;
                imm_d = {{20{ins.r.funct7[6]}}, ins.r.rd[0], ins.r.funct7[5:0],
                         ins.r.rd[4:1], 1'b0};
            end
            default: ;
        endcase
        // Writes to x0 are dropped here, before they enter the pipe
        if (ins.r.rd == '0) begin
            ctrl_d.reg_write = 1'b0;
        end
        if (!i_if_id.valid) begin
            ctrl_d = '0;
        end
    end

    // Load in EX whose result is needed here
    assign o_stall = i_if_id.valid && id_ex_q.ctrl.mem_read && id_ex_q.rd != '0 &&
                     (id_ex_q.rd == ins.r.rs1 || (uses_rs2 && id_ex_q.rd == ins.r.rs2));

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            id_ex_q.ctrl <= '0;
        end else if (i_run) begin
            id_ex_q.ctrl     <= (i_flush || o_stall) ? '0 : ctrl_d;
            id_ex_q.pc       <= i_if_id.pc;
            id_ex_q.rs1_data <= rs1_data;
            id_ex_q.rs2_data <= rs2_data;
            id_ex_q.imm      <= imm_d;
            id_ex_q.rs1      <= ins.r.rs1;
            id_ex_q.rs2      <= ins.r.rs2;
            id_ex_q.rd       <= ins.r.rd;
        end
    end

    always_ff @(posedge clk) begin
        dbg_q <= regs[i_dbg_addr];
    end

    assign o_id_ex    = id_ex_q;
    assign o_dbg_data = dbg_q;

endmodule

//--- rv_execute.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage: operand forwarding, ALU, BEQ
// resolution and the EX/MEM register.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rv_execute (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_run,
    input  rv_pkg::id_ex_t          i_id_ex,
    input  rv_pkg::wb_t             i_wb,
    output logic                    o_flush,
    output logic [rv_pkg::XLEN-1:0] o_target,
    output rv_pkg::ex_mem_t         o_ex_mem
);
    import rv_pkg::*;

    ex_mem_t         ex_mem_q;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b_reg;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;

    // Youngest producer first, then write-back, then the register file value
    function automatic logic [XLEN-1:0] fwd(input logic [REG_AW-1:0] rs,
                                            input logic [XLEN-1:0]   rf_data,
                                            input ex_mem_t           mem,
                                            input wb_t               wb);
        logic [XLEN-1:0] val;
        val = rf_data;
        if (rs != '0 && mem.reg_write && mem.rd == rs) begin
            val = mem.alu;
        end else if (rs != '0 && wb.we && wb.rd == rs) begin
            val = wb.data;
        end
        return val;
    endfunction

    assign op_a     = fwd(i_id_ex.rs1, i_id_ex.rs1_data, ex_mem_q, i_wb);
    assign op_b_reg = fwd(i_id_ex.rs2, i_id_ex.rs2_data, ex_mem_q, i_wb);
    assign op_b     = i_id_ex.ctrl.alu_src ? i_id_ex.imm : op_b_reg;

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_res = op_a + op_b;
        endcase
    end

    // BEQ taken when the forwarded operands match
    assign o_flush  = i_id_ex.ctrl.branch && (op_a == op_b_reg);
    assign o_target = i_id_ex.pc + i_id_ex.imm;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            ex_mem_q.reg_write  <= 1'b0;
            ex_mem_q.mem_read   <= 1'b0;
            ex_mem_q.mem_write  <= 1'b0;
            ex_mem_q.mem_to_reg <= 1'b0;
        end else if (i_run) begin
            ex_mem_q.reg_write  <= i_id_ex.ctrl.reg_write && !o_flush;
            ex_mem_q.mem_read   <= i_id_ex.ctrl.mem_read;
            ex_mem_q.mem_write  <= i_id_ex.ctrl.mem_write && !o_flush;
            ex_mem_q.mem_to_reg <= i_id_ex.ctrl.mem_to_reg;
            ex_mem_q.alu        <= alu_res;
            ex_mem_q.store_data <= op_b_reg;
            ex_mem_q.rd         <= i_id_ex.rd;
        end
    end

    assign o_ex_mem = ex_mem_q;

endmodule

//--- rv_memory.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory stage: word-addressed data memory and the
// MEM/WB register that forms the write-back request.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rv_memory #(
    parameter int DMEM_AW = 5
) (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_run,
    input  rv_pkg::ex_mem_t i_ex_mem,
    output rv_pkg::wb_t     o_wb
);
    import rv_pkg::*;

    logic [XLEN-1:0]    dmem [2**DMEM_AW];
    logic [DMEM_AW-1:0] addr;
    logic [XLEN-1:0]    load_data;
    wb_t                wb_q;

    // Byte address from the ALU, low two bits ignored
    assign addr = i_ex_mem.alu[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (i_run && i_ex_mem.mem_write) begin
            dmem[addr] <= i_ex_mem.store_data;
        end
    end

    assign load_data = i_ex_mem.mem_read ? dmem[addr] : '0;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wb_q.we <= 1'b0;
        end else if (i_run) begin
            wb_q.we   <= i_ex_mem.reg_write;
            wb_q.rd   <= i_ex_mem.rd;
            wb_q.data <= i_ex_mem.mem_to_reg ? load_data : i_ex_mem.alu;
        end
    end

    assign o_wb = wb_q;

endmodule

//--- rv_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the pipelined core. Programs are
// loaded with i_run low; registers are read back
// through the debug port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rv_core #(
    parameter int IMEM_AW = 6,
    parameter int DMEM_AW = 5
) (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_run,
    input  logic                      i_load_en,
    input  logic [IMEM_AW-1:0]        i_load_addr,
    input  logic [rv_pkg::XLEN-1:0]   i_load_data,
    input  logic [rv_pkg::REG_AW-1:0] i_dbg_addr,
    output logic [rv_pkg::XLEN-1:0]   o_pc,
    output logic [rv_pkg::XLEN-1:0]   o_dbg_data
);
    import rv_pkg::*;

    if_id_t          if_id;
    id_ex_t          id_ex;
    ex_mem_t         ex_mem;
    wb_t             wb;
    logic            stall;
    logic            flush;
    logic [XLEN-1:0] target;

    rv_fetch #(.IMEM_AW(IMEM_AW)) fetch_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_run(i_run),
        .i_load_en(i_load_en), .i_load_addr(i_load_addr), .i_load_data(i_load_data),
        .i_stall(stall), .i_flush(flush), .i_target(target),
        .o_pc(o_pc), .o_if_id(if_id)
    );

    rv_decode decode_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_run(i_run),
        .i_if_id(if_id), .i_flush(flush), .i_wb(wb), .i_dbg_addr(i_dbg_addr),
        .o_stall(stall), .o_id_ex(id_ex), .o_dbg_data(o_dbg_data)
    );

    rv_execute execute_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_run(i_run),
        .i_id_ex(id_ex), .i_wb(wb),
        .o_flush(flush), .o_target(target), .o_ex_mem(ex_mem)
    );

    rv_memory #(.DMEM_AW(DMEM_AW)) memory_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_run(i_run),
        .i_ex_mem(ex_mem), .o_wb(wb)
    );

endmodule

//--- rv_core_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on the core's pipeline control,
// bound into rv_core from the testbench file list.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rv_core_assert (
    input logic                    clk,
    input logic                    i_rst_n,
    input logic                    i_run,
    input logic [rv_pkg::XLEN-1:0] i_pc,
    input rv_pkg::wb_t             i_wb,
    input logic                    i_flush,
    input rv_pkg::if_id_t          i_if_id
);

    // Core held, PC frozen
    pc_holds: assert property (@(posedge clk) disable iff (!i_rst_n)
        !i_run |=> $stable(i_pc))
        else $error("PC changed while the core was held");

    no_x0_write: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_wb.we |-> i_wb.rd != '0)
        else $error("Write-back targeted x0 with its enable set");

    // Flush wins even when a stall is pending
    flush_clears: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_run && i_flush) |=> !i_if_id.valid)
        else $error("IF/ID still valid after a flush");

endmodule

bind rv_core rv_core_assert assert_i (
    .clk(clk), .i_rst_n(i_rst_n), .i_run(i_run), .i_pc(o_pc),
    .i_wb(wb), .i_flush(flush), .i_if_id(if_id)
);

//--- rv_core_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the pipelined core. Each table row is
// a short program that is loaded, run to its BEQ halt
// loop, and then checked by a debug read of one register.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rv_core_tb;
    localparam int          IMEM_AW    = 6;
    localparam int          DMEM_AW    = 5;
    localparam int          NUM_ROWS   = 6;
    localparam int          MAX_CYCLES = 200;
    localparam logic [31:0] HALT       = 32'h0000_0063;
    localparam logic [31:0] NOP        = 32'h0000_0013;
    localparam logic [6:0]  OP_IMM     = 7'b0010011;
    localparam logic [6:0]  LOAD       = 7'b0000011;

    typedef struct packed {
        logic [0:7][31:0] prog;
        logic [4:0]       rd;
        logic [31:0]      exp_val;
    } row_t;

    logic               clk;
    logic               rst_n;
    logic               run;
    logic               load_en;
    logic [IMEM_AW-1:0] load_addr;
    logic [31:0]        load_data;
    logic [4:0]         dbg_addr;
    logic [31:0]        pc;
    logic [31:0]        dbg_data;
    row_t               rows [NUM_ROWS];
    string              names [NUM_ROWS];
    int                 errors;
    int                 timeouts;

    rv_core #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) dut_i (
        .clk(clk), .i_rst_n(rst_n), .i_run(run),
        .i_load_en(load_en), .i_load_addr(load_addr), .i_load_data(load_data),
        .i_dbg_addr(dbg_addr), .o_pc(pc), .o_dbg_data(dbg_data)
    );

    always #5 clk = ~clk;

    // RV32I encodings
    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beq_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic build_table();
        logic [11:0] a;
        logic [11:0] b;
        logic [31:0] sa;
        logic [31:0] sb;
        a  = 12'($urandom);
        b  = 12'($urandom);
        sa = {{20{a[11]}}, a};
        sb = {{20{b[11]}}, b};
        names = '{"fwd_chain", "load_use", "beq_taken", "beq_not_taken", "logic_ops",
                  "x0_write"};
        rows[0] = '{prog: {itype(OP_IMM, 0, 1, 0, a), itype(OP_IMM, 0, 2, 1, b),
                           rtype(0, 0, 3, 1, 2), rtype(7'h20, 0, 4, 3, 1),
                           rtype(0, 0, 5, 4, 3), HALT, NOP, NOP},
                    rd: 5, exp_val: 3 * sa + 2 * sb};
        rows[1] = '{prog: {itype(OP_IMM, 0, 1, 0, 77), itype(OP_IMM, 0, 4, 0, 5),
                           sw_word(1, 0, 8), itype(LOAD, 3'b010, 2, 0, 8),
                           rtype(0, 0, 3, 2, 4), HALT, NOP, NOP},
                    rd: 3, exp_val: 32'd77 + 32'd5};
        // Both skipped ADDIs target x2
        rows[2] = '{prog: {itype(OP_IMM, 0, 1, 0, 3), beq_word(1, 1, 12),
                           itype(OP_IMM, 0, 2, 0, 7), itype(OP_IMM, 0, 2, 2, 9),
                           HALT, NOP, NOP, NOP},
                    rd: 2, exp_val: 0};
        rows[3] = '{prog: {itype(OP_IMM, 0, 1, 0, 1), itype(OP_IMM, 0, 2, 0, 2),
                           beq_word(1, 2, 8), itype(OP_IMM, 0, 3, 0, 9),
                           HALT, NOP, NOP, NOP},
                    rd: 3, exp_val: 9};
        // x3 = 2, x4 = -5, x5 = -7, signed x6 = 1, so x7 = -6
        rows[4] = '{prog: {itype(OP_IMM, 0, 1, 0, 12'hffa), itype(OP_IMM, 0, 2, 0, 3),
                           rtype(0, 3'b111, 3, 1, 2), rtype(0, 3'b110, 4, 1, 2),
                           rtype(0, 3'b100, 5, 3, 4), rtype(0, 3'b010, 6, 1, 2),
                           rtype(0, 0, 7, 5, 6), HALT},
                    rd: 7,
                    exp_val: 32'hffff_fffa};
        rows[5] = '{prog: {itype(OP_IMM, 0, 0, 0, 5), HALT, NOP, NOP, NOP, NOP, NOP, NOP},
                    rd: 0, exp_val: 0};
    endtask

    task automatic pulse_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // Debug data is registered, so it is ready one edge later
    task automatic read_reg(input logic [4:0] addr, output logic [31:0] val);
        dbg_addr = addr;
        @(negedge clk);
        val = dbg_data;
    endtask

    task automatic check_reset_state(input string name);
        logic [31:0] val;
        if (pc !== 32'h0) begin
            $display("Error: %s o_pc after reset expected %h, got %h", name, 32'h0, pc);
            errors++;
        end
        for (int r = 0; r < 32; r++) begin
            read_reg(5'(r), val);
            if (val !== 32'h0) begin
                $display("Error: %s x%0d after reset expected %h, got %h", name, r, 32'h0, val);
                errors++;
            end
        end
    endtask

    task automatic run_row(input int idx);
        int          halt_idx;
        int          seen;
        int          cycles;
        logic [31:0] val;
        halt_idx = 0;
        for (int k = 7; k >= 0; k--) begin
            if (rows[idx].prog[k] == HALT) begin
                halt_idx = k;
            end
        end
        pulse_reset();
        check_reset_state(names[idx]);
        // Words past the program are padded with NOPs
        for (int k = 0; k < 16; k++) begin
            load_en   = 1'b1;
            load_addr = IMEM_AW'(k);
            load_data = (k < 8) ? rows[idx].prog[k] : NOP;
            @(negedge clk);
        end
        load_en = 1'b0;
        run     = 1'b1;
        seen    = 0;
        cycles  = 0;
        while (seen < 8 && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (pc == 32'(halt_idx * 4)) begin
                seen++;
            end
        end
        run = 1'b0;
        if (seen < 8) begin
            $display("Timeout: %s did not reach its halt loop", names[idx]);
            timeouts++;
        end
        read_reg(rows[idx].rd, val);
        if (val !== rows[idx].exp_val) begin
            $display("Error: %s x%0d expected %h, got %h", names[idx], rows[idx].rd,
                     rows[idx].exp_val, val);
            errors++;
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        dbg_addr  = '0;
        errors    = 0;
        timeouts  = 0;
        void'($urandom(32'h888));
        build_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_memory.sv
rv_core.sv
rv_core_assert.sv
rv_core_tb.sv
